// File: Bender.yml
package:
  name: secv_mem_subsys

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/secv_pkg.sv
      - rtl/mtag_chk.sv
      - rtl/mem_fu.sv
      - rtl/wb_dmem.sv
      - rtl/wb_tmem.sv
      - rtl/secv_mem_subsys.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/mem_checker.sv
      - verif/tb_mem_subsys.sv

// File: flist.f
+incdir+rtl
rtl/secv_pkg.sv
rtl/mtag_chk.sv
rtl/mem_fu.sv
rtl/wb_dmem.sv
rtl/wb_tmem.sv
rtl/secv_mem_subsys.sv
verif/mem_checker.sv
verif/tb_mem_subsys.sv

// File: rtl/mem_fu.sv
// Memory function unit with load/store decode, fault checks, data bus master and result forming
`include "secv_defs.svh"

module mem_fu
    import secv_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  funit_in_t                 fu_i,
    output funit_out_t                fu_o,
    input  logic                      tchk_done_i,
    input  logic                      tag_err_i,
    output logic                      dmem_cyc_o,
    output logic                      dmem_stb_o,
    output logic [`SECV_XLEN/8-1:0]   dmem_sel_o,
    output dadr_t                     dmem_adr_o,
    output logic                      dmem_we_o,
    output xlen_t                     dmem_dat_o,
    input  xlen_t                     dmem_dat_i,
    input  logic                      dmem_ack_i
);

    localparam int SEL_W = `SECV_XLEN / 8;

    mfu_state_t       state_q;
    mfu_state_t       state_d;
    logic [SEL_W-1:0] sel;
    logic             load;
    logic             valid;
    logic             fault;
    logic             go;
    logic             bus_act;
    xlen_t            wdat;
    xlen_t            rdat;
    dadr_t            dadr;
    ecode_t           fault_code;

    assign dadr = fu_i.src1[`SECV_DADR_W+2:3];

    // Op decode with data always in the low lanes
    always_comb begin
        sel   = '0;
        load  = 1'b0;
        valid = 1'b1;
        wdat  = '0;
        rdat  = '0;
        case (fu_i.op)
            MEM_OP_LB: begin
                sel  = SEL_W'(8'h01);
                load = 1'b1;
                rdat = sext8(dmem_dat_i[7:0]);
            end
            MEM_OP_LH: begin
                sel  = SEL_W'(8'h03);
                load = 1'b1;
                rdat = sext16(dmem_dat_i[15:0]);
            end
            MEM_OP_LW: begin
                sel  = SEL_W'(8'h0f);
                load = 1'b1;
                rdat = sext32(dmem_dat_i[31:0]);
            end
            MEM_OP_LD: begin
                sel  = SEL_W'(8'hff);
                load = 1'b1;
                rdat = dmem_dat_i;
            end
            MEM_OP_LBU: begin
                sel  = SEL_W'(8'h01);
                load = 1'b1;
                rdat = xlen_t'(dmem_dat_i[7:0]);
            end
            MEM_OP_LHU: begin
                sel  = SEL_W'(8'h03);
                load = 1'b1;
                rdat = xlen_t'(dmem_dat_i[15:0]);
            end
            MEM_OP_LWU: begin
                sel  = SEL_W'(8'h0f);
                load = 1'b1;
                rdat = xlen_t'(dmem_dat_i[31:0]);
            end
            MEM_OP_SB: begin
                sel  = SEL_W'(8'h01);
                wdat = xlen_t'(fu_i.src2[7:0]);
            end
            MEM_OP_SH: begin
                sel  = SEL_W'(8'h03);
                wdat = xlen_t'(fu_i.src2[15:0]);
            end
            MEM_OP_SW: begin
                sel  = SEL_W'(8'h0f);
                wdat = xlen_t'(fu_i.src2[31:0]);
            end
            MEM_OP_SD: begin
                sel  = SEL_W'(8'hff);
                wdat = fu_i.src2;
            end
            default: valid = 1'b0;
        endcase
    end

    // Fault priority: invalid op, then tag, then address mask
    always_comb begin
        fault      = 1'b1;
        fault_code = ECODE_NONE;
        if (!valid) begin
            fault_code = ECODE_OP_INVALID;
        end else if (tag_err_i) begin
            fault_code = load ? ECODE_MTAG_LOAD_INVLD : ECODE_MTAG_STORE_INVLD;
        end else if ((dadr & `SECV_ADR_FAULT_MASK) != '0) begin
            fault_code = load ? ECODE_LOAD_ACCESS_FAULT : ECODE_STORE_ACCESS_FAULT;
        end else begin
            fault = 1'b0;
        end
    end

    // Bus cycle opens as soon as a clean tag check arrives
    assign go      = (state_q == TAG) && fu_i.ena && tchk_done_i && !fault;
    assign bus_act = go || (state_q == ACCESS);

    assign dmem_cyc_o = bus_act;
    assign dmem_stb_o = bus_act;
    assign dmem_sel_o = bus_act ? sel : '0;
    assign dmem_adr_o = bus_act ? dadr : '0;
    assign dmem_we_o  = bus_act && !load;
    assign dmem_dat_o = bus_act ? wdat : '0;

    always_comb begin
        state_d     = state_q;
        fu_o        = '0;
        fu_o.ecode  = ECODE_NONE;
        case (state_q)
            TAG: begin
                if (fu_i.ena && tchk_done_i) begin
                    if (fault) begin
                        fu_o.rdy   = 1'b1;
                        fu_o.err   = 1'b1;
                        fu_o.ecode = fault_code;
                        state_d    = RESP;
                    end else begin
                        state_d = ACCESS;
                    end
                end
            end
            ACCESS: begin
                if (dmem_ack_i) begin
                    fu_o.rdy    = 1'b1;
                    fu_o.res    = rdat;
                    fu_o.res_wb = load;
                    state_d     = RESP;
                end
            end
            // Wait for the core to drop ena
            RESP: begin
                if (!fu_i.ena) begin
                    state_d = TAG;
                end
            end
            default: state_d = TAG;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= TAG;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: rtl/mtag_chk.sv
// Tag checker that fetches the granule tag over Wishbone and compares it with the pointer tag
`include "secv_defs.svh"

module mtag_chk
    import secv_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                ena_i,
    input  xlen_t                               adr_i,
    output logic                                done_o,
    output logic                                err_o,
    output logic                                tmem_cyc_o,
    output logic                                tmem_stb_o,
    output logic [`SECV_TLEN/`SECV_TAG_W-1:0]   tmem_sel_o,
    output tadr_t                               tmem_adr_o,
    input  logic [`SECV_TLEN-1:0]               tmem_dat_i,
    input  logic                                tmem_ack_i
);

    localparam int NIB_N  = `SECV_TLEN / `SECV_TAG_W;
    localparam int NIB_W  = $clog2(NIB_N);
    // One 16-byte granule per tag gives src1[10:4]
    localparam int GIDX_W = `SECV_DADR_W - 1;

    tchk_state_t       state_q;
    logic [GIDX_W-1:0] gidx;
    logic [NIB_W-1:0]  nib;
    tag_t              ptag;
    tag_t              mtag;

    assign ptag = adr_i[`SECV_XLEN-1 -: `SECV_TAG_W];
    assign gidx = adr_i[GIDX_W+3:4];
    assign nib  = gidx[NIB_W-1:0];

    // Tag of the addressed granule within the returned word
    assign mtag = tmem_dat_i[nib*`SECV_TAG_W +: `SECV_TAG_W];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            tmem_cyc_o <= 1'b0;
            tmem_stb_o <= 1'b0;
            done_o     <= 1'b0;
            err_o      <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (ena_i) begin
                        tmem_cyc_o <= 1'b1;
                        tmem_stb_o <= 1'b1;
                        state_q    <= FETCH;
                    end
                end
                FETCH: begin
                    if (tmem_ack_i) begin
                        tmem_cyc_o <= 1'b0;
                        tmem_stb_o <= 1'b0;
                        done_o     <= 1'b1;
                        err_o      <= (mtag != ptag);
                        state_q    <= DONE;
                    end
                end
                DONE: begin
                    // Result held until the core drops ena
                    if (!ena_i) begin
                        done_o  <= 1'b0;
                        err_o   <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Tag word address and nibble select latched at request start
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && ena_i) begin
            tmem_adr_o <= tadr_t'(gidx[GIDX_W-1:NIB_W]);
            tmem_sel_o <= NIB_N'(1) << nib;
        end
    end

endmodule

// File: rtl/secv_defs.svh
// Width and geometry macros for the tagged memory subsystem, plus the access fault mask
`ifndef SECV_DEFS_SVH
`define SECV_DEFS_SVH

// Data path width
`define SECV_XLEN 64

// Data RAM word address for 256 doublewords
`define SECV_DADR_W 8

// Allocation and pointer tag width
`define SECV_TAG_W 4

// Tag RAM word holds four granule tags
`define SECV_TLEN 16

// Tag RAM word address width
`define SECV_TADR_W 7

// Doubleword addresses with bit 7 set fault
// The upper half of data memory is off limits
`define SECV_ADR_FAULT_MASK 8'h80

`endif

// File: rtl/secv_mem_subsys.sv
// Top level with memory function unit, tag checker, data RAM and tag RAM
`include "secv_defs.svh"

module secv_mem_subsys
    import secv_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  funit_in_t               fu_i,
    output funit_out_t              fu_o,
    output logic                    tag_err_o,
    input  logic                    tag_we_i,
    input  logic [`SECV_TADR_W+1:0] tag_gidx_i,
    input  tag_t                    tag_dat_i
);

    // Tag check handshake
    logic tchk_done;

    // Data bus
    logic                    dmem_cyc;
    logic                    dmem_stb;
    logic [`SECV_XLEN/8-1:0] dmem_sel;
    dadr_t                   dmem_adr;
    logic                    dmem_we;
    xlen_t                   dmem_wdat;
    xlen_t                   dmem_rdat;
    logic                    dmem_ack;

    // Tag bus
    logic                              tmem_cyc;
    logic                              tmem_stb;
    logic [`SECV_TLEN/`SECV_TAG_W-1:0] tmem_sel;
    tadr_t                             tmem_adr;
    logic [`SECV_TLEN-1:0]             tmem_dat;
    logic                              tmem_ack;

    mem_fu mem_fu_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .fu_i        (fu_i),
        .fu_o        (fu_o),
        .tchk_done_i (tchk_done),
        .tag_err_i   (tag_err_o),
        .dmem_cyc_o  (dmem_cyc),
        .dmem_stb_o  (dmem_stb),
        .dmem_sel_o  (dmem_sel),
        .dmem_adr_o  (dmem_adr),
        .dmem_we_o   (dmem_we),
        .dmem_dat_o  (dmem_wdat),
        .dmem_dat_i  (dmem_rdat),
        .dmem_ack_i  (dmem_ack)
    );

    mtag_chk mtag_chk_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ena_i      (fu_i.ena),
        .adr_i      (fu_i.src1),
        .done_o     (tchk_done),
        .err_o      (tag_err_o),
        .tmem_cyc_o (tmem_cyc),
        .tmem_stb_o (tmem_stb),
        .tmem_sel_o (tmem_sel),
        .tmem_adr_o (tmem_adr),
        .tmem_dat_i (tmem_dat),
        .tmem_ack_i (tmem_ack)
    );

    wb_dmem wb_dmem_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cyc_i   (dmem_cyc),
        .stb_i   (dmem_stb),
        .sel_i   (dmem_sel),
        .adr_i   (dmem_adr),
        .we_i    (dmem_we),
        .dat_i   (dmem_wdat),
        .dat_o   (dmem_rdat),
        .ack_o   (dmem_ack)
    );

    wb_tmem wb_tmem_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cyc_i   (tmem_cyc),
        .stb_i   (tmem_stb),
        .sel_i   (tmem_sel),
        .adr_i   (tmem_adr),
        .dat_o   (tmem_dat),
        .ack_o   (tmem_ack),
        .we_i    (tag_we_i),
        .gidx_i  (tag_gidx_i),
        .tag_i   (tag_dat_i)
    );

endmodule

// File: rtl/secv_pkg.sv
// Package with data, address, opcode, error code, FU struct and FSM types plus sign extension
`include "secv_defs.svh"

package secv_pkg;

    typedef logic [`SECV_XLEN-1:0]   xlen_t;
    typedef logic [`SECV_TAG_W-1:0]  tag_t;
    typedef logic [`SECV_DADR_W-1:0] dadr_t;
    typedef logic [`SECV_TADR_W-1:0] tadr_t;

    // Codes 7 and 12..15 are invalid
    typedef enum logic [3:0] {
        MEM_OP_LB  = 4'd0,
        MEM_OP_LH  = 4'd1,
        MEM_OP_LW  = 4'd2,
        MEM_OP_LD  = 4'd3,
        MEM_OP_LBU = 4'd4,
        MEM_OP_LHU = 4'd5,
        MEM_OP_LWU = 4'd6,
        MEM_OP_SB  = 4'd8,
        MEM_OP_SH  = 4'd9,
        MEM_OP_SW  = 4'd10,
        MEM_OP_SD  = 4'd11
    } mem_op_t;

    // Access faults follow the RISC-V cause numbers
    typedef enum logic [4:0] {
        ECODE_NONE               = 5'd0,
        ECODE_OP_INVALID         = 5'd2,
        ECODE_LOAD_ACCESS_FAULT  = 5'd5,
        ECODE_STORE_ACCESS_FAULT = 5'd7,
        ECODE_MTAG_LOAD_INVLD    = 5'd24,
        ECODE_MTAG_STORE_INVLD   = 5'd25
    } ecode_t;

    typedef struct packed {
        logic    ena;
        mem_op_t op;
        xlen_t   src1;
        xlen_t   src2;
    } funit_in_t;

    typedef struct packed {
        logic   rdy;
        logic   err;
        ecode_t ecode;
        xlen_t  res;
        logic   res_wb;
    } funit_out_t;

    typedef enum logic [1:0] {IDLE, FETCH, DONE} tchk_state_t;

    typedef enum logic [1:0] {TAG, ACCESS, RESP} mfu_state_t;

    function automatic xlen_t sext8(input logic [7:0] v);
        return {{(`SECV_XLEN-8){v[7]}}, v};
    endfunction

    function automatic xlen_t sext16(input logic [15:0] v);
        return {{(`SECV_XLEN-16){v[15]}}, v};
    endfunction

    function automatic xlen_t sext32(input logic [31:0] v);
        return {{(`SECV_XLEN-32){v[31]}}, v};
    endfunction

endpackage

// File: rtl/wb_dmem.sv
// Wishbone data RAM with byte lane writes, registered read data and one-cycle ack
`include "secv_defs.svh"

module wb_dmem
    import secv_pkg::*;
#(
    parameter int DEPTH = 2 ** `SECV_DADR_W
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    cyc_i,
    input  logic                    stb_i,
    input  logic [`SECV_XLEN/8-1:0] sel_i,
    input  dadr_t                   adr_i,
    input  logic                    we_i,
    input  xlen_t                   dat_i,
    output xlen_t                   dat_o,
    output logic                    ack_o
);

    localparam int SEL_W = `SECV_XLEN / 8;

    xlen_t mem [DEPTH];
    logic  req;

    // The ack cycle does not count as a new request
    assign req = cyc_i && stb_i && !ack_o;

    always_ff @(posedge clk_i) begin
        if (req && we_i) begin
            for (int b = 0; b < SEL_W; b++) begin
                if (sel_i[b]) begin
                    mem[adr_i][b*8 +: 8] <= dat_i[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req && !we_i) begin
            dat_o <= mem[adr_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req;
        end
    end

endmodule

// File: rtl/wb_tmem.sv
// Tag RAM with a nibble-selectable Wishbone read port and an external single-tag write port
`include "secv_defs.svh"

module wb_tmem
    import secv_pkg::*;
#(
    parameter int DEPTH = 2 ** `SECV_TADR_W
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              cyc_i,
    input  logic                              stb_i,
    input  logic [`SECV_TLEN/`SECV_TAG_W-1:0] sel_i,
    input  tadr_t                             adr_i,
    output logic [`SECV_TLEN-1:0]             dat_o,
    output logic                              ack_o,
    input  logic                              we_i,
    input  logic [`SECV_TADR_W+1:0]           gidx_i,
    input  tag_t                              tag_i
);

    localparam int NIB_N = `SECV_TLEN / `SECV_TAG_W;

    logic [`SECV_TLEN-1:0] mem [DEPTH];
    logic [`SECV_TLEN-1:0] rmask;
    tadr_t                 wadr;
    logic [1:0]            wnib;
    logic                  req;

    // Granule index splits into word and nibble
    assign wadr = gidx_i[`SECV_TADR_W+1:2];
    assign wnib = gidx_i[1:0];
    assign req  = cyc_i && stb_i && !ack_o;

    // Unselected nibbles read as zero
    always_comb begin
        for (int n = 0; n < NIB_N; n++) begin
            rmask[n*`SECV_TAG_W +: `SECV_TAG_W] = {`SECV_TAG_W{sel_i[n]}};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[wadr][wnib*`SECV_TAG_W +: `SECV_TAG_W] <= tag_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            dat_o <= mem[adr_i] & rmask;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req;
        end
    end

endmodule

// File: verif/mem_checker.sv
// Monitor with a byte and tag reference model that checks every completed memory operation
`include "secv_defs.svh"

module mem_checker
    import secv_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  funit_in_t               fu_req_i,
    input  funit_out_t              fu_rsp_i,
    input  logic                    tag_err_i,
    input  logic                    tag_we_i,
    input  logic [`SECV_TADR_W+1:0] tag_gidx_i,
    input  tag_t                    tag_dat_i,
    output int                      err_cnt_o,
    output int                      op_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // Cycles an operation may wait for rdy
    localparam int ANSWER_LIMIT = 16;

    logic [7:0] bytes_q [2**`SECV_DADR_W][8];
    tag_t       tags_q [2**(`SECV_TADR_W+2)];
    logic       seen_ena;
    logic       answered;
    int         wait_cnt;

    initial begin
        err_cnt_o = 0;
        op_cnt_o  = 0;
        seen_ena  = 1'b0;
        answered  = 1'b0;
        wait_cnt  = 0;
        // Data RAM has no reset and tag RAM clears to zero
        foreach (bytes_q[a, b]) bytes_q[a][b] = 'x;
        foreach (tags_q[g]) tags_q[g] = '0;
    end

    // Access size in bytes or zero for an invalid opcode
    function automatic int op_bytes(input mem_op_t op);
        case (op)
            MEM_OP_LB, MEM_OP_LBU, MEM_OP_SB: return 1;
            MEM_OP_LH, MEM_OP_LHU, MEM_OP_SH: return 2;
            MEM_OP_LW, MEM_OP_LWU, MEM_OP_SW: return 4;
            MEM_OP_LD, MEM_OP_SD:             return 8;
            default:                          return 0;
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        if (act !== exp) begin
            $display("error at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
            err_cnt_o++;
        end
    endtask

    task automatic complain(input string what);
        $display("at %0d ns: %s", $time, what);
        err_cnt_o++;
    endtask

    task automatic check_op();
        xlen_t       addr;
        dadr_t       dadr;
        int          nbytes;
        bit          load;
        bit          sgn;
        bit          mism;
        bit          ok;
        ecode_t      exp_code;
        logic [63:0] exp_res;
        addr     = fu_req_i.src1;
        dadr     = addr[10:3];
        nbytes   = op_bytes(fu_req_i.op);
        load     = fu_req_i.op inside {MEM_OP_LB, MEM_OP_LH, MEM_OP_LW, MEM_OP_LD,
                                       MEM_OP_LBU, MEM_OP_LHU, MEM_OP_LWU};
        sgn      = fu_req_i.op inside {MEM_OP_LB, MEM_OP_LH, MEM_OP_LW};
        mism     = tags_q[addr[10:4]] != addr[63:60];
        exp_code = ECODE_NONE;
        if (nbytes == 0) begin
            exp_code = ECODE_OP_INVALID;
        end else if (mism) begin
            exp_code = load ? ECODE_MTAG_LOAD_INVLD : ECODE_MTAG_STORE_INVLD;
        end else if ((dadr & `SECV_ADR_FAULT_MASK) != '0) begin
            exp_code = load ? ECODE_LOAD_ACCESS_FAULT : ECODE_STORE_ACCESS_FAULT;
        end
        ok = (exp_code == ECODE_NONE);
        compare_field("fu_o.err", !ok, fu_rsp_i.err);
        compare_field("fu_o.ecode", exp_code, fu_rsp_i.ecode);
        compare_field("fu_o.res_wb", ok && load, fu_rsp_i.res_wb);
        // Tag check runs for invalid ops as well
        compare_field("tag_err_o", mism, tag_err_i);
        if (ok && load) begin
            exp_res = '0;
            for (int b = 0; b < 8; b++) begin
                if (b < nbytes)
                    exp_res[b*8 +: 8] = bytes_q[dadr][b];
                else if (sgn)
                    exp_res[b*8 +: 8] = {8{bytes_q[dadr][nbytes-1][7]}};
            end
            compare_field("fu_o.res", exp_res, fu_rsp_i.res);
        end
        // Store data lands in the low lanes
        if (ok && !load) begin
            for (int b = 0; b < nbytes; b++) begin
                bytes_q[dadr][b] = fu_req_i.src2[b*8 +: 8];
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            answered = 1'b0;
            wait_cnt = 0;
        end else begin
            if (tag_we_i) tags_q[tag_gidx_i] = tag_dat_i;
            if (!seen_ena && (fu_rsp_i.rdy || tag_err_i))
                complain("rdy or tag_err_o went high before the first operation");
            if (fu_req_i.ena) seen_ena = 1'b1;
            if (fu_rsp_i.rdy && !fu_req_i.ena) begin
                complain("rdy pulse while ena is low");
            end else if (fu_rsp_i.rdy && answered) begin
                complain("second rdy pulse for one operation");
            end else if (fu_rsp_i.rdy) begin
                check_op();
                answered = 1'b1;
                op_cnt_o++;
            end
            if (!fu_req_i.ena) begin
                answered = 1'b0;
                wait_cnt = 0;
            end else if (!answered) begin
                wait_cnt++;
                if (wait_cnt == ANSWER_LIMIT) complain("ena was never answered with rdy");
            end
        end
    end

endmodule

// File: verif/tb_mem_subsys.sv
// Testbench top with clock, reset, tag setup, seeded random loads and stores, and a run limit
`include "secv_defs.svh"

module tb_mem_subsys
    import secv_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED       = 51644;
    localparam int RST_CYCLES = 10;
    localparam int N_TAGS     = 64;
    localparam int N_OPS      = 300;
    // Doubleword stores that fill the lower window first
    localparam int INIT_OPS   = 32;
    localparam int CYCLE_LIMIT = RST_CYCLES + N_TAGS + N_OPS * 6 + 100;

    logic                    clk;
    logic                    rst_n;
    funit_in_t               fu_req;
    funit_out_t              fu_rsp;
    logic                    tag_err;
    logic                    tag_we;
    logic [`SECV_TADR_W+1:0] tag_gidx;
    tag_t                    tag_dat;
    int                      err_cnt;
    int                      op_cnt;
    int                      cycle_cnt = 0;
    // Granule tags as written for picking pointer tags
    tag_t                    tag_tb [128];

    secv_mem_subsys secv_mem_subsys_i (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .fu_i       (fu_req),
        .fu_o       (fu_rsp),
        .tag_err_o  (tag_err),
        .tag_we_i   (tag_we),
        .tag_gidx_i (tag_gidx),
        .tag_dat_i  (tag_dat)
    );

    mem_checker mem_checker_i (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .fu_req_i   (fu_req),
        .fu_rsp_i   (fu_rsp),
        .tag_err_i  (tag_err),
        .tag_we_i   (tag_we),
        .tag_gidx_i (tag_gidx),
        .tag_dat_i  (tag_dat),
        .err_cnt_o  (err_cnt),
        .op_cnt_o   (op_cnt)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic xlen_t make_addr(input tag_t ptag, input dadr_t dadr);
        return {ptag, 49'b0, dadr, 3'b000};
    endfunction

    task automatic write_tag(input int gidx, input tag_t tag);
        tag_we   <= 1'b1;
        tag_gidx <= gidx[`SECV_TADR_W+1:0];
        tag_dat  <= tag;
        tag_tb[gidx] = tag;
        @(posedge clk);
    endtask

    // Hold the request until rdy and then idle one cycle
    task automatic run_op(input mem_op_t op, input xlen_t addr, input xlen_t data);
        fu_req.op   <= op;
        fu_req.src1 <= addr;
        fu_req.src2 <= data;
        fu_req.ena  <= 1'b1;
        @(posedge clk);
        while (!fu_rsp.rdy) @(posedge clk);
        fu_req.ena <= 1'b0;
        @(posedge clk);
    endtask

    task automatic random_op();
        dadr_t      dadr;
        tag_t       ptag;
        int         r;
        logic [3:0] code;
        dadr = dadr_t'($urandom % 32);
        if ($urandom % 2) dadr = dadr + 8'd128;
        ptag = tag_tb[dadr >> 1];
        // Roughly 30 percent wrong pointer tags
        if ($urandom % 100 >= 70) ptag = ptag ^ tag_t'(1 + $urandom % 15);
        if ($urandom % 100 < 5) begin
            r    = $urandom % 5;
            code = (r == 0) ? 4'd7 : 4'(11 + r);
        end else begin
            r    = $urandom % 11;
            code = (r < 7) ? 4'(r) : 4'(r + 1);
        end
        run_op(mem_op_t'(code), make_addr(ptag, dadr), {$urandom, $urandom});
    endtask

    task automatic end_run(input bit timed_out);
        int total;
        total = err_cnt;
        if (timed_out) begin
            $display("run stopped at cycle %0d before all operations finished", cycle_cnt);
            total++;
        end
        if (op_cnt != N_OPS) begin
            $display("only %0d of %0d operations completed", op_cnt, N_OPS);
            total++;
        end
        $display("%0d operations checked, %0d errors", op_cnt, total);
        if (total == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    endtask

    initial begin
        void'($urandom(SEED));
        foreach (tag_tb[g]) tag_tb[g] = '0;
        rst_n    = 1'b0;
        fu_req   = '0;
        tag_we   = 1'b0;
        tag_gidx = '0;
        tag_dat  = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        // Granules 0..31 and 64..95 cover both address windows
        for (int i = 0; i < N_TAGS; i++) begin
            write_tag((i < 32) ? i : i + 32, tag_t'($urandom % 16));
        end
        tag_we <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < INIT_OPS; i++) begin
            run_op(MEM_OP_SD, make_addr(tag_tb[i >> 1], dadr_t'(i)), {$urandom, $urandom});
        end
        for (int i = INIT_OPS; i < N_OPS; i++) begin
            random_op();
        end
        repeat (4) @(posedge clk);
        end_run(1'b0);
    end

    initial begin
        wait (cycle_cnt == CYCLE_LIMIT);
        end_run(1'b1);
    end

endmodule
